/* src/ex_consts.svh */
`ifndef EX_CONSTS_SVH
`define EX_CONSTS_SVH

// Data path and PC width
`define XLEN 32

// Register file address width
`define REG_AW 5

// Internal data memory geometry
`define DMEM_WORDS 256
`define DMEM_AW 8

`endif

/* src/ex_pkg.sv */
`include "ex_consts.svh"

package ex_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_PASS2              // Operand two straight through
    } alu_op_e;

    typedef enum logic [2:0] {
        MEM_B,
        MEM_H,
        MEM_W,
        MEM_BU,
        MEM_HU
    } mem_type_e;

    typedef enum logic [2:0] {
        WB_ALU,
        WB_LOAD,
        WB_MUL_LO,
        WB_MUL_HI,
        WB_CNT_LO,
        WB_CNT_HI
    } wb_sel_e;

    typedef struct packed {
        logic [`XLEN-1:0] hi;
        logic [`XLEN-1:0] lo;
    } result64_s;

    // Product and counter are both read as one word or as two halves
    typedef union packed {
        logic [2*`XLEN-1:0] full;
        result64_s          half;
    } result64_u;

endpackage

/* src/operand_forward.sv */
`timescale 1ns/10ps
`include "ex_consts.svh"

module operand_forward (
    input  logic [`REG_AW-1:0] ex_rs1_a,
    input  logic [`REG_AW-1:0] ex_rs2_a,
    input  logic [`REG_AW-1:0] ex_rs1_b,
    input  logic [`REG_AW-1:0] ex_rs2_b,
    input  logic [`XLEN-1:0]   ex_rdata1_a,
    input  logic [`XLEN-1:0]   ex_rdata2_a,
    input  logic [`XLEN-1:0]   ex_rdata1_b,
    input  logic [`XLEN-1:0]   ex_rdata2_b,
    input  logic               mem_we_a,
    input  logic               mem_we_b,
    input  logic [`REG_AW-1:0] mem_waddr_a,
    input  logic [`REG_AW-1:0] mem_waddr_b,
    input  logic [`XLEN-1:0]   mem_alu_a,
    input  logic [`XLEN-1:0]   mem_alu_b,
    input  ex_pkg::wb_sel_e    mem_sel_b,
    input  logic               wb_we_a,
    input  logic               wb_we_b,
    input  logic [`REG_AW-1:0] wb_waddr_a,
    input  logic [`REG_AW-1:0] wb_waddr_b,
    input  logic [`XLEN-1:0]   wb_wdata_a,
    input  logic [`XLEN-1:0]   wb_wdata_b,
    output logic [`XLEN-1:0]   fwd1_a,
    output logic [`XLEN-1:0]   fwd2_a,
    output logic [`XLEN-1:0]   fwd1_b,
    output logic [`XLEN-1:0]   fwd2_b
);
    import ex_pkg::*;

    logic mem_b_ok;
    logic mem_a_ok;
    logic wb_b_ok;
    logic wb_a_ok;

    // Lane B in MEM only has a usable value for ALU results
    assign mem_b_ok = mem_we_b && (mem_sel_b == WB_ALU) && (mem_waddr_b != '0);
    assign mem_a_ok = mem_we_a && (mem_waddr_a != '0);
    assign wb_b_ok  = wb_we_b && (wb_waddr_b != '0);
    assign wb_a_ok  = wb_we_a && (wb_waddr_a != '0);

    // Youngest result wins, lane B before lane A
    function automatic logic [`XLEN-1:0] pick(input logic [`REG_AW-1:0] rs,
                                              input logic [`XLEN-1:0]   raw);
        if (mem_b_ok && rs == mem_waddr_b) return mem_alu_b;
        if (mem_a_ok && rs == mem_waddr_a) return mem_alu_a;
        if (wb_b_ok && rs == wb_waddr_b) return wb_wdata_b;
        if (wb_a_ok && rs == wb_waddr_a) return wb_wdata_a;
        return raw;
    endfunction

    always_comb begin
        fwd1_a = pick(ex_rs1_a, ex_rdata1_a);
        fwd2_a = pick(ex_rs2_a, ex_rdata2_a);
        fwd1_b = pick(ex_rs1_b, ex_rdata1_b);
        fwd2_b = pick(ex_rs2_b, ex_rdata2_b);
    end

endmodule

/* src/alu.sv */
`timescale 1ns/10ps
`include "ex_consts.svh"

module alu (
    input  logic [`XLEN-1:0] pc,
    input  logic [`XLEN-1:0] rdata1,
    input  logic [`XLEN-1:0] rdata2,
    input  logic [`XLEN-1:0] imm,
    input  logic             src1_pc,
    input  logic             src2_imm,
    input  ex_pkg::alu_op_e  op,
    output logic [`XLEN-1:0] result
);
    import ex_pkg::*;

    logic [`XLEN-1:0] opa;
    logic [`XLEN-1:0] opb;
    logic [4:0]       shamt;

    assign opa   = src1_pc ? pc : rdata1;        // PC for auipc style ops
    assign opb   = src2_imm ? imm : rdata2;
    assign shamt = opb[4:0];

    always_comb begin
        case (op)
            ALU_ADD:   result = opa + opb;
            ALU_SUB:   result = opa - opb;
            ALU_AND:   result = opa & opb;
            ALU_OR:    result = opa | opb;
            ALU_XOR:   result = opa ^ opb;
            ALU_SLL:   result = opa << shamt;
            ALU_SRL:   result = opa >> shamt;
            ALU_SRA:   result = $signed(opa) >>> shamt;
            ALU_SLT: begin
                result = {{(`XLEN-1){1'b0}}, $signed(opa) < $signed(opb)};
            end
            ALU_SLTU: begin
                result = {{(`XLEN-1){1'b0}}, opa < opb};
            end
            ALU_PASS2: result = opb;                 // lui style immediate
            default:   result = '0;
        endcase
    end

endmodule

/* src/mul_pipe.sv */
`timescale 1ns/10ps
`include "ex_consts.svh"

module mul_pipe (
    input  logic              clk,
    input  logic [`XLEN-1:0]  x,
    input  logic [`XLEN-1:0]  y,
    input  logic              is_signed,
    output ex_pkg::result64_u product
);
    logic [2*`XLEN-1:0] x_ext;
    logic [2*`XLEN-1:0] y_hi_ext;
    logic [2*`XLEN-1:0] pp_lo;
    logic [2*`XLEN-1:0] pp_hi;
    logic [2*`XLEN-1:0] pp_lo_q;
    logic [2*`XLEN-1:0] pp_hi_q;

    // Sign only matters for x and the top half of y
    assign x_ext    = {{`XLEN{is_signed & x[`XLEN-1]}}, x};
    assign y_hi_ext = {{(`XLEN+16){is_signed & y[`XLEN-1]}}, y[`XLEN-1:16]};

    // Both products wrap modulo 2^64
    assign pp_lo = x_ext * {{(`XLEN+16){1'b0}}, y[15:0]};
    assign pp_hi = (x_ext * y_hi_ext) << 16;

    always_ff @(posedge clk) begin
        pp_lo_q <= pp_lo;
        pp_hi_q <= pp_hi;
    end

    assign product.full = pp_lo_q + pp_hi_q;      // Final sum in MEM

endmodule

/* src/data_mem.sv */
`timescale 1ns/10ps
`include "ex_consts.svh"

module data_mem (
    input  logic              clk,
    input  logic              we,
    input  logic              re,
    input  logic [`XLEN-1:0]  addr,
    input  logic [`XLEN-1:0]  wdata,
    input  ex_pkg::mem_type_e mem_type,
    output logic [`XLEN-1:0]  rdata
);
    import ex_pkg::*;

    logic [`XLEN-1:0]   mem [`DMEM_WORDS];
    logic [`DMEM_AW-1:0] idx;
    logic [3:0]         be;
    logic [`XLEN-1:0]   wdata_rep;
    logic [`XLEN-1:0]   merged;
    logic [`XLEN-1:0]   rd_word;
    logic [1:0]         off_q;
    mem_type_e          type_q;
    logic [7:0]         ld_byte;
    logic [15:0]        ld_half;

    assign idx = addr[`DMEM_AW+1:2];             // Wraps at the memory depth

    always_comb begin
        case (mem_type)
            MEM_B, MEM_BU: begin
                be        = 4'b0001 << addr[1:0];
                wdata_rep = {4{wdata[7:0]}};
            end
            MEM_H, MEM_HU: begin
                be        = addr[1] ? 4'b1100 : 4'b0011;
                wdata_rep = {2{wdata[15:0]}};
            end
            default: begin
                be        = 4'b1111;
                wdata_rep = wdata;
            end
        endcase
        for (int i = 0; i < 4; i++) begin
            merged[8*i +: 8] = be[i] ? wdata_rep[8*i +: 8] : mem[idx][8*i +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            mem[idx] <= merged;
        end
        if (re) begin
            rd_word <= we ? merged : mem[idx];   // Write-first
            off_q   <= addr[1:0];
            type_q  <= mem_type;
        end
    end

    assign ld_byte = rd_word[8*off_q +: 8];
    assign ld_half = rd_word[16*off_q[1] +: 16];

    always_comb begin
        case (type_q)
            MEM_B:   rdata = {{(`XLEN-8){ld_byte[7]}}, ld_byte};
            MEM_BU:  rdata = {{(`XLEN-8){1'b0}}, ld_byte};
            MEM_H:   rdata = {{(`XLEN-16){ld_half[15]}}, ld_half};
            MEM_HU:  rdata = {{(`XLEN-16){1'b0}}, ld_half};
            default: rdata = rd_word;
        endcase
    end

endmodule

/* src/stage_regs.sv */
`timescale 1ns/10ps
`include "ex_consts.svh"

module stage_regs (
    input  logic               clk,
    input  logic               reset,
    input  logic               ex_valid_a,
    input  logic               ex_valid_b,
    input  logic [`XLEN-1:0]   ex_pc_a,
    input  logic [`XLEN-1:0]   ex_pc_b,
    input  logic               ex_rf_we_a,
    input  logic               ex_rf_we_b,
    input  logic [`REG_AW-1:0] ex_waddr_a,
    input  logic [`REG_AW-1:0] ex_waddr_b,
    input  logic [`XLEN-1:0]   ex_alu_a,
    input  logic [`XLEN-1:0]   ex_alu_b,
    input  ex_pkg::wb_sel_e    ex_sel_b,
    input  logic [`XLEN-1:0]   mem_rdata,
    input  ex_pkg::result64_u  mem_product,
    output logic               mem_we_a,
    output logic               mem_we_b,
    output logic [`REG_AW-1:0] mem_waddr_a,
    output logic [`REG_AW-1:0] mem_waddr_b,
    output logic [`XLEN-1:0]   mem_alu_a,
    output logic [`XLEN-1:0]   mem_alu_b,
    output ex_pkg::wb_sel_e    mem_sel_b,
    output logic               wb_we_a,
    output logic               wb_we_b,
    output logic [`REG_AW-1:0] wb_waddr_a,
    output logic [`REG_AW-1:0] wb_waddr_b,
    output logic [`XLEN-1:0]   wb_wdata_a,
    output logic [`XLEN-1:0]   wb_wdata_b,
    output logic [`XLEN-1:0]   wb_pc_a,
    output logic [`XLEN-1:0]   wb_pc_b
);
    import ex_pkg::*;

    result64_u        counter;          // Stable counter, free running
    result64_u        mem_cnt;
    logic [`XLEN-1:0] mem_pc_a;
    logic [`XLEN-1:0] mem_pc_b;
    logic [`XLEN-1:0] mem_wdata_b;

    always_ff @(posedge clk) begin
        if (reset) begin
            counter.full <= '0;
        end else begin
            counter.full <= counter.full + 1'b1;
        end
    end

    // EX to MEM
    always_ff @(posedge clk) begin
        if (reset) begin
            mem_we_a <= 1'b0;
            mem_we_b <= 1'b0;
        end else begin
            mem_we_a <= ex_valid_a & ex_rf_we_a;
            mem_we_b <= ex_valid_b & ex_rf_we_b;
        end
    end

    always_ff @(posedge clk) begin
        mem_waddr_a <= ex_waddr_a;
        mem_waddr_b <= ex_waddr_b;
        mem_alu_a   <= ex_alu_a;
        mem_alu_b   <= ex_alu_b;
        mem_sel_b   <= ex_sel_b;
        mem_pc_a    <= ex_pc_a;
        mem_pc_b    <= ex_pc_b;
        mem_cnt     <= counter;        // Value seen in the EX cycle
    end

    // Lane B result source
    always_comb begin
        case (mem_sel_b)
            WB_LOAD:   mem_wdata_b = mem_rdata;
            WB_MUL_LO: mem_wdata_b = mem_product.half.lo;
            WB_MUL_HI: mem_wdata_b = mem_product.half.hi;
            WB_CNT_LO: mem_wdata_b = mem_cnt.half.lo;
            WB_CNT_HI: mem_wdata_b = mem_cnt.half.hi;
            default:   mem_wdata_b = mem_alu_b;
        endcase
    end

    // MEM to WB
    always_ff @(posedge clk) begin
        if (reset) begin
            wb_we_a <= 1'b0;
            wb_we_b <= 1'b0;
        end else begin
            wb_we_a <= mem_we_a;
            wb_we_b <= mem_we_b;
        end
    end

    always_ff @(posedge clk) begin
        wb_waddr_a <= mem_waddr_a;
        wb_waddr_b <= mem_waddr_b;
        wb_wdata_a <= mem_alu_a;
        wb_wdata_b <= mem_wdata_b;
        wb_pc_a    <= mem_pc_a;
        wb_pc_b    <= mem_pc_b;
    end

endmodule

/* src/ex_mem_wb.sv */
`timescale 1ns/10ps
`include "ex_consts.svh"

module ex_mem_wb (
    input  logic               clk,
    input  logic               reset,
    input  logic               ex_valid_a,
    input  logic [`XLEN-1:0]   ex_pc_a,
    input  logic [`REG_AW-1:0] ex_rs1_a,
    input  logic [`REG_AW-1:0] ex_rs2_a,
    input  logic [`XLEN-1:0]   ex_rdata1_a,
    input  logic [`XLEN-1:0]   ex_rdata2_a,
    input  logic [`XLEN-1:0]   ex_imm_a,
    input  logic               ex_src1_pc_a,
    input  logic               ex_src2_imm_a,
    input  ex_pkg::alu_op_e    ex_alu_op_a,
    input  logic               ex_rf_we_a,
    input  logic [`REG_AW-1:0] ex_waddr_a,
    input  logic               ex_valid_b,
    input  logic [`XLEN-1:0]   ex_pc_b,
    input  logic [`REG_AW-1:0] ex_rs1_b,
    input  logic [`REG_AW-1:0] ex_rs2_b,
    input  logic [`XLEN-1:0]   ex_rdata1_b,
    input  logic [`XLEN-1:0]   ex_rdata2_b,
    input  logic [`XLEN-1:0]   ex_imm_b,
    input  logic               ex_src1_pc_b,
    input  logic               ex_src2_imm_b,
    input  ex_pkg::alu_op_e    ex_alu_op_b,
    input  logic               ex_rf_we_b,
    input  logic [`REG_AW-1:0] ex_waddr_b,
    input  ex_pkg::wb_sel_e    ex_wb_sel_b,
    input  logic               ex_mem_we_b,
    input  ex_pkg::mem_type_e  ex_mem_type_b,
    input  logic               ex_mul_signed_b,
    output logic               wb_we_a,
    output logic [`REG_AW-1:0] wb_waddr_a,
    output logic [`XLEN-1:0]   wb_wdata_a,
    output logic [`XLEN-1:0]   wb_pc_a,
    output logic               wb_we_b,
    output logic [`REG_AW-1:0] wb_waddr_b,
    output logic [`XLEN-1:0]   wb_wdata_b,
    output logic [`XLEN-1:0]   wb_pc_b
);
    import ex_pkg::*;

    logic [`XLEN-1:0]   fwd1_a;
    logic [`XLEN-1:0]   fwd2_a;
    logic [`XLEN-1:0]   fwd1_b;
    logic [`XLEN-1:0]   fwd2_b;
    logic [`XLEN-1:0]   alu_res_a;
    logic [`XLEN-1:0]   alu_res_b;
    logic               mem_we_a;
    logic               mem_we_b;
    logic [`REG_AW-1:0] mem_waddr_a;
    logic [`REG_AW-1:0] mem_waddr_b;
    logic [`XLEN-1:0]   mem_alu_a;
    logic [`XLEN-1:0]   mem_alu_b;
    wb_sel_e            mem_sel_b;
    logic [`XLEN-1:0]   mem_rdata;
    result64_u          mem_product;
    logic               dmem_we;
    logic               dmem_re;

    assign dmem_we = ex_valid_b & ex_mem_we_b;              // Store only with the strobe
    assign dmem_re = ex_valid_b && (ex_wb_sel_b == WB_LOAD);

    operand_forward fwd_i (
        .ex_rs1_a(ex_rs1_a), .ex_rs2_a(ex_rs2_a),
        .ex_rs1_b(ex_rs1_b), .ex_rs2_b(ex_rs2_b),
        .ex_rdata1_a(ex_rdata1_a), .ex_rdata2_a(ex_rdata2_a),
        .ex_rdata1_b(ex_rdata1_b), .ex_rdata2_b(ex_rdata2_b),
        .mem_we_a(mem_we_a), .mem_we_b(mem_we_b),
        .mem_waddr_a(mem_waddr_a), .mem_waddr_b(mem_waddr_b),
        .mem_alu_a(mem_alu_a), .mem_alu_b(mem_alu_b), .mem_sel_b(mem_sel_b),
        .wb_we_a(wb_we_a), .wb_we_b(wb_we_b),
        .wb_waddr_a(wb_waddr_a), .wb_waddr_b(wb_waddr_b),
        .wb_wdata_a(wb_wdata_a), .wb_wdata_b(wb_wdata_b),
        .fwd1_a(fwd1_a), .fwd2_a(fwd2_a), .fwd1_b(fwd1_b), .fwd2_b(fwd2_b)
    );

    alu alu_a (
        .pc(ex_pc_a), .rdata1(fwd1_a), .rdata2(fwd2_a), .imm(ex_imm_a),
        .src1_pc(ex_src1_pc_a), .src2_imm(ex_src2_imm_a), .op(ex_alu_op_a),
        .result(alu_res_a)
    );

    alu alu_b (
        .pc(ex_pc_b), .rdata1(fwd1_b), .rdata2(fwd2_b), .imm(ex_imm_b),
        .src1_pc(ex_src1_pc_b), .src2_imm(ex_src2_imm_b), .op(ex_alu_op_b),
        .result(alu_res_b)
    );

    mul_pipe mul_i (
        .clk(clk), .x(fwd1_b), .y(fwd2_b), .is_signed(ex_mul_signed_b),
        .product(mem_product)
    );

    // Address from lane B ALU, store data from forwarded rs2
    data_mem dmem_i (
        .clk(clk), .we(dmem_we), .re(dmem_re), .addr(alu_res_b),
        .wdata(fwd2_b), .mem_type(ex_mem_type_b), .rdata(mem_rdata)
    );

    stage_regs regs_i (
        .clk(clk), .reset(reset),
        .ex_valid_a(ex_valid_a), .ex_valid_b(ex_valid_b),
        .ex_pc_a(ex_pc_a), .ex_pc_b(ex_pc_b),
        .ex_rf_we_a(ex_rf_we_a), .ex_rf_we_b(ex_rf_we_b),
        .ex_waddr_a(ex_waddr_a), .ex_waddr_b(ex_waddr_b),
        .ex_alu_a(alu_res_a), .ex_alu_b(alu_res_b), .ex_sel_b(ex_wb_sel_b),
        .mem_rdata(mem_rdata), .mem_product(mem_product),
        .mem_we_a(mem_we_a), .mem_we_b(mem_we_b),
        .mem_waddr_a(mem_waddr_a), .mem_waddr_b(mem_waddr_b),
        .mem_alu_a(mem_alu_a), .mem_alu_b(mem_alu_b), .mem_sel_b(mem_sel_b),
        .wb_we_a(wb_we_a), .wb_we_b(wb_we_b),
        .wb_waddr_a(wb_waddr_a), .wb_waddr_b(wb_waddr_b),
        .wb_wdata_a(wb_wdata_a), .wb_wdata_b(wb_wdata_b),
        .wb_pc_a(wb_pc_a), .wb_pc_b(wb_pc_b)
    );

endmodule

/* tb/ex_model.svh */
`ifndef EX_MODEL_SVH
`define EX_MODEL_SVH

typedef struct packed {
    logic               valid;
    logic               we;
    logic [`REG_AW-1:0] waddr;
    logic [`XLEN-1:0]   wdata;
    logic [`XLEN-1:0]   pc;
} lane_exp_t;

logic [`XLEN-1:0]   arch_rf [1 << `REG_AW];    // In-order state right after issue
logic [`XLEN-1:0]   ext_rf [1 << `REG_AW];     // Outside register file, written at WB end
logic [`XLEN-1:0]   ref_mem [`DMEM_WORDS];
logic [2*`XLEN-1:0] ref_count;                 // Cycles since reset fell
lane_exp_t          exp_a [TOTAL_STEPS];       // Expected WB, indexed by issue step
lane_exp_t          exp_b [TOTAL_STEPS];

task automatic clear_model();
    for (int i = 0; i < (1 << `REG_AW); i++) begin
        arch_rf[i] = '0;
        ext_rf[i]  = '0;
    end
    for (int i = 0; i < TOTAL_STEPS; i++) begin
        exp_a[i] = '0;
        exp_b[i] = '0;
    end
    ref_count = '0;
endtask

function automatic logic [`XLEN-1:0] alu_result(alu_op_e op, logic [`XLEN-1:0] a,
                                                logic [`XLEN-1:0] b);
    case (op)
        ALU_ADD:  return a + b;
        ALU_SUB:  return a - b;
        ALU_AND:  return a & b;
        ALU_OR:   return a | b;
        ALU_XOR:  return a ^ b;
        ALU_SLL:  return a << b[4:0];
        ALU_SRL:  return a >> b[4:0];
        ALU_SRA:  return $signed(a) >>> b[4:0];
        ALU_SLT:  return ($signed(a) < $signed(b)) ? 1 : 0;
        ALU_SLTU: return (a < b) ? 1 : 0;
        default:  return b;                    // Pass-second
    endcase
endfunction

function automatic logic [2*`XLEN-1:0] full_product(logic [`XLEN-1:0] x, logic [`XLEN-1:0] y,
                                                    logic sgn);
    longint sx;
    longint sy;
    sx = sgn ? {{`XLEN{x[`XLEN-1]}}, x} : {{`XLEN{1'b0}}, x};
    sy = sgn ? {{`XLEN{y[`XLEN-1]}}, y} : {{`XLEN{1'b0}}, y};
    return sx * sy;                            // Low 64 bits are exact either way
endfunction

function automatic logic [`XLEN-1:0] load_value(logic [`XLEN-1:0] word, logic [1:0] off,
                                                mem_type_e t);
    logic [`XLEN-1:0] shifted;
    shifted = word >> (8 * off);
    case (t)
        MEM_B:   return {{(`XLEN-8){shifted[7]}}, shifted[7:0]};
        MEM_BU:  return {{(`XLEN-8){1'b0}}, shifted[7:0]};
        MEM_H:   return {{(`XLEN-16){shifted[15]}}, shifted[15:0]};
        MEM_HU:  return {{(`XLEN-16){1'b0}}, shifted[15:0]};
        default: return word;
    endcase
endfunction

task automatic store_bytes(logic [`XLEN-1:0] addr, logic [`XLEN-1:0] data, mem_type_e t);
    int idx;
    int nbytes;
    idx    = (addr >> 2) % `DMEM_WORDS;
    nbytes = (t == MEM_W) ? 4 : ((t == MEM_H || t == MEM_HU) ? 2 : 1);
    for (int i = 0; i < nbytes; i++) begin
        ref_mem[idx][8*(addr[1:0]+i) +: 8] = data[8*i +: 8];
    end
endtask

// Runs the pair in program order, lane A before lane B
task automatic exec_pair(int step);
    logic [`XLEN-1:0]   a1;
    logic [`XLEN-1:0]   a2;
    logic [`XLEN-1:0]   b1;
    logic [`XLEN-1:0]   b2;
    logic [`XLEN-1:0]   res_a;
    logic [`XLEN-1:0]   res_b;
    logic [`XLEN-1:0]   addr;
    logic [2*`XLEN-1:0] prod;
    a1    = arch_rf[ex_rs1_a];
    a2    = arch_rf[ex_rs2_a];
    b1    = arch_rf[ex_rs1_b];
    b2    = arch_rf[ex_rs2_b];
    res_a = alu_result(ex_alu_op_a, ex_src1_pc_a ? ex_pc_a : a1, ex_src2_imm_a ? ex_imm_a : a2);
    res_b = alu_result(ex_alu_op_b, ex_src1_pc_b ? ex_pc_b : b1, ex_src2_imm_b ? ex_imm_b : b2);
    addr  = res_b;
    prod  = full_product(b1, b2, ex_mul_signed_b);
    if (ex_valid_b && ex_mem_we_b) store_bytes(addr, b2, ex_mem_type_b);
    case (ex_wb_sel_b)
        WB_LOAD:   res_b = load_value(ref_mem[(addr >> 2) % `DMEM_WORDS], addr[1:0], ex_mem_type_b);
        WB_MUL_LO: res_b = prod[`XLEN-1:0];
        WB_MUL_HI: res_b = prod[2*`XLEN-1:`XLEN];
        WB_CNT_LO: res_b = ref_count[`XLEN-1:0];
        WB_CNT_HI: res_b = ref_count[2*`XLEN-1:`XLEN];
        default:   ;
    endcase
    exp_a[step] = '{valid: ex_valid_a, we: ex_valid_a & ex_rf_we_a, waddr: ex_waddr_a,
                    wdata: res_a, pc: ex_pc_a};
    exp_b[step] = '{valid: ex_valid_b, we: ex_valid_b & ex_rf_we_b, waddr: ex_waddr_b,
                    wdata: res_b, pc: ex_pc_b};
    if (exp_a[step].we && ex_waddr_a != '0) arch_rf[ex_waddr_a] = res_a;
    if (exp_b[step].we && ex_waddr_b != '0) arch_rf[ex_waddr_b] = res_b;
endtask

// Register file write at the end of the WB cycle
task automatic write_ext_rf(int step);
    if (exp_a[step].we && exp_a[step].waddr != '0) ext_rf[exp_a[step].waddr] = exp_a[step].wdata;
    if (exp_b[step].we && exp_b[step].waddr != '0) ext_rf[exp_b[step].waddr] = exp_b[step].wdata;
endtask

`endif

/* tb/tb_ex_mem_wb.sv */
`timescale 1ns/10ps
`include "ex_consts.svh"

module tb_ex_mem_wb;
    import ex_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 4;
    localparam int N_STEPS      = 800;          // Issue slots, the first two idle
    localparam int TOTAL_STEPS  = N_STEPS + 2;  // Two more to drain WB
    localparam int MEM_SPAN     = 16;           // Words used by loads and stores
    localparam int WARMUP_END   = 2 + MEM_SPAN;
    localparam int WATCHDOG_NS  = (TOTAL_STEPS + RESET_CYCLES + 20) * CLK_PERIOD;
    localparam logic [`XLEN-1:0] HIGH_MASK = ~(`XLEN'(`DMEM_WORDS * 4 - 1));

    logic               clk;
    logic               reset;
    logic               ex_valid_a;
    logic [`XLEN-1:0]   ex_pc_a;
    logic [`REG_AW-1:0] ex_rs1_a;
    logic [`REG_AW-1:0] ex_rs2_a;
    logic [`XLEN-1:0]   ex_rdata1_a;
    logic [`XLEN-1:0]   ex_rdata2_a;
    logic [`XLEN-1:0]   ex_imm_a;
    logic               ex_src1_pc_a;
    logic               ex_src2_imm_a;
    alu_op_e            ex_alu_op_a;
    logic               ex_rf_we_a;
    logic [`REG_AW-1:0] ex_waddr_a;
    logic               ex_valid_b;
    logic [`XLEN-1:0]   ex_pc_b;
    logic [`REG_AW-1:0] ex_rs1_b;
    logic [`REG_AW-1:0] ex_rs2_b;
    logic [`XLEN-1:0]   ex_rdata1_b;
    logic [`XLEN-1:0]   ex_rdata2_b;
    logic [`XLEN-1:0]   ex_imm_b;
    logic               ex_src1_pc_b;
    logic               ex_src2_imm_b;
    alu_op_e            ex_alu_op_b;
    logic               ex_rf_we_b;
    logic [`REG_AW-1:0] ex_waddr_b;
    wb_sel_e            ex_wb_sel_b;
    logic               ex_mem_we_b;
    mem_type_e          ex_mem_type_b;
    logic               ex_mul_signed_b;
    logic               wb_we_a;
    logic [`REG_AW-1:0] wb_waddr_a;
    logic [`XLEN-1:0]   wb_wdata_a;
    logic [`XLEN-1:0]   wb_pc_a;
    logic               wb_we_b;
    logic [`REG_AW-1:0] wb_waddr_b;
    logic [`XLEN-1:0]   wb_wdata_b;
    logic [`XLEN-1:0]   wb_pc_b;

    logic [`REG_AW-1:0] busy_reg;               // Non-ALU lane B dest of the last step
    int                 last_store_word;

    `include "ex_model.svh"

    ex_mem_wb dut_i (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stop_run(string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1, "Run stopped");
    endtask

    task automatic check_word(string name, logic [`XLEN-1:0] exp, logic [`XLEN-1:0] act);
        if (act !== exp) stop_run($sformatf("[FAIL] %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_addr(string name, logic [`REG_AW-1:0] exp, logic [`REG_AW-1:0] act);
        if (act !== exp) stop_run($sformatf("[FAIL] %s expected %0d actual %0d", name, exp, act));
    endtask

    task automatic check_we(string name, logic exp, logic act);
        if (act !== exp) stop_run($sformatf("[FAIL] %s expected %b actual %b", name, exp, act));
    endtask

    task automatic compare_lane(string tag, lane_exp_t e, logic we, logic [`REG_AW-1:0] waddr,
                                logic [`XLEN-1:0] wdata, logic [`XLEN-1:0] pc);
        check_we({tag, " wb_we"}, e.we, we);
        if (e.valid) begin
            check_addr({tag, " wb_waddr"}, e.waddr, waddr);
            check_word({tag, " wb_pc"}, e.pc, pc);
        end
        if (e.we) check_word({tag, " wb_wdata"}, e.wdata, wdata);
    endtask

    // Random source register, never one of the two hazard registers unless it is x0
    function automatic logic [`REG_AW-1:0] pick_src(logic [`REG_AW-1:0] avoid1,
                                                    logic [`REG_AW-1:0] avoid2);
        logic [`REG_AW-1:0] r;
        do begin
            r = $urandom_range(0, 7);
        end while (r != '0 && (r == avoid1 || r == avoid2));
        return r;
    endfunction

    task automatic clear_inputs();
        {ex_valid_a, ex_pc_a, ex_rs1_a, ex_rs2_a, ex_rdata1_a, ex_rdata2_a, ex_imm_a} = '0;
        {ex_src1_pc_a, ex_src2_imm_a, ex_rf_we_a, ex_waddr_a} = '0;
        {ex_valid_b, ex_pc_b, ex_rs1_b, ex_rs2_b, ex_rdata1_b, ex_rdata2_b, ex_imm_b} = '0;
        {ex_src1_pc_b, ex_src2_imm_b, ex_rf_we_b, ex_waddr_b, ex_mem_we_b, ex_mul_signed_b} = '0;
        ex_alu_op_a   = ALU_ADD;
        ex_alu_op_b   = ALU_ADD;
        ex_wb_sel_b   = WB_ALU;
        ex_mem_type_b = MEM_W;
    endtask

    task automatic drive_pair(int step);
        logic [`REG_AW-1:0] a_dest;
        logic [`XLEN-1:0]   addr;
        int                 kind;
        int                 word;
        int                 off;
        bit                 idle;
        bit                 warmup;
        idle   = (step < 2) || (step >= N_STEPS);
        warmup = (step >= 2) && (step < WARMUP_END);  // Word stores fill the memory span
        ex_valid_a    = !idle && ($urandom_range(0, 7) != 0);
        ex_pc_a       = 32'h0000_1000 + 8 * step;
        ex_rs1_a      = pick_src(busy_reg, busy_reg);
        ex_rs2_a      = pick_src(busy_reg, busy_reg);
        ex_imm_a      = $urandom();
        ex_src1_pc_a  = ($urandom_range(0, 3) == 0);
        ex_src2_imm_a = $urandom_range(0, 1);
        ex_alu_op_a   = alu_op_e'($urandom_range(0, 10));
        ex_rf_we_a    = ($urandom_range(0, 7) != 0);
        ex_waddr_a    = $urandom_range(0, 7);
        a_dest        = (ex_valid_a && ex_rf_we_a) ? ex_waddr_a : '0;

        ex_valid_b      = warmup || (!idle && ($urandom_range(0, 7) != 0));
        ex_pc_b         = ex_pc_a + 4;
        ex_rs1_b        = pick_src(busy_reg, a_dest);  // No same-pair A to B dependency
        ex_rs2_b        = pick_src(busy_reg, a_dest);
        ex_imm_b        = $urandom();
        ex_src1_pc_b    = ($urandom_range(0, 3) == 0);
        ex_src2_imm_b   = $urandom_range(0, 1);
        ex_alu_op_b     = alu_op_e'($urandom_range(0, 10));
        ex_rf_we_b      = ($urandom_range(0, 7) != 0);
        ex_waddr_b      = $urandom_range(0, 7);
        ex_wb_sel_b     = WB_ALU;
        ex_mem_we_b     = 1'b0;
        ex_mem_type_b   = MEM_W;
        ex_mul_signed_b = $urandom_range(0, 1);
        kind            = warmup ? 2 : $urandom_range(0, 7);  // 1 load, 2 store, 3 to 6 others
        word            = -1;

        if (kind == 1 || kind == 2) begin
            if (warmup) begin
                word = step - 2;
            end else begin
                word = $urandom_range(0, MEM_SPAN - 1);
                if (kind == 1 && last_store_word >= 0 && $urandom_range(0, 1) == 1) begin
                    word = last_store_word;              // Load right behind a store
                end
                ex_mem_type_b = mem_type_e'(kind == 1 ? $urandom_range(0, 4)
                                                      : $urandom_range(0, 2));
            end
            case (ex_mem_type_b)
                MEM_W:         off = 0;
                MEM_H, MEM_HU: off = 2 * $urandom_range(0, 1);
                default:       off = $urandom_range(0, 3);
            endcase
            addr          = ($urandom() & HIGH_MASK) | (word << 2) | off;
            ex_src1_pc_b  = 1'b0;
            ex_src2_imm_b = 1'b1;
            ex_alu_op_b   = ALU_ADD;
            ex_imm_b      = addr - arch_rf[ex_rs1_b];   // Base plus offset lands on addr
            ex_rf_we_b    = (kind == 1);
            ex_mem_we_b   = (kind == 2);
            if (kind == 1) ex_wb_sel_b = WB_LOAD;
        end else if (kind >= 3 && kind <= 6) begin
            case (kind)
                3:       ex_wb_sel_b = WB_MUL_LO;
                4:       ex_wb_sel_b = WB_MUL_HI;
                5:       ex_wb_sel_b = WB_CNT_LO;
                default: ex_wb_sel_b = WB_CNT_HI;
            endcase
            ex_rf_we_b = 1'b1;
        end

        ex_rdata1_a     = ext_rf[ex_rs1_a];
        ex_rdata2_a     = ext_rf[ex_rs2_a];
        ex_rdata1_b     = ext_rf[ex_rs1_b];
        ex_rdata2_b     = ext_rf[ex_rs2_b];
        busy_reg        = (ex_valid_b && ex_rf_we_b && ex_wb_sel_b != WB_ALU) ? ex_waddr_b : '0;
        last_store_word = (ex_valid_b && kind == 2) ? word : -1;
    endtask

    initial begin
        #(WATCHDOG_NS);
        stop_run("Timeout: the run did not reach its end in the expected time");
    end

    initial begin
        void'($urandom(32'hc7a7_b452));
        clk             = 1'b0;
        reset           = 1'b1;
        busy_reg        = '0;
        last_store_word = -1;
        clear_inputs();
        clear_model();
        repeat (RESET_CYCLES) @(posedge clk);
        for (int step = 0; step < TOTAL_STEPS; step++) begin
            #2;
            reset = 1'b0;
            // WB now holds the pair issued two steps back
            if (step >= 2) begin
                compare_lane($sformatf("lane a issue %0d", step - 2), exp_a[step - 2],
                             wb_we_a, wb_waddr_a, wb_wdata_a, wb_pc_a);
                compare_lane($sformatf("lane b issue %0d", step - 2), exp_b[step - 2],
                             wb_we_b, wb_waddr_b, wb_wdata_b, wb_pc_b);
            end else begin
                check_we("wb_we_a after reset", 1'b0, wb_we_a);
                check_we("wb_we_b after reset", 1'b0, wb_we_b);
            end
            if (step >= 3) write_ext_rf(step - 3);
            drive_pair(step);
            exec_pair(step);
            ref_count = ref_count + 1;
            @(posedge clk);
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* list.f */
+incdir+src
+incdir+tb
src/ex_pkg.sv
src/operand_forward.sv
src/alu.sv
src/mul_pipe.sv
src/data_mem.sv
src/stage_regs.sv
src/ex_mem_wb.sv
tb/tb_ex_mem_wb.sv

/* run.sh */
#!/bin/sh
# Compile and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --timescale 1ns/10ps -Wno-fatal \
    --top-module tb_ex_mem_wb -f list.f -o tb_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"

if grep -q "Simulation finished: FAIL" "$SIM_LOG"; then
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi
exit 0
